// ==== include/pipe_trace_defines.svh ====
//////////////////////////////////////////////////////////////////////
// Pipeline trace unit widths and depth
// Shared by the type packages and the tracker logic
//////////////////////////////////////////////////////////////////////
`ifndef PIPE_TRACE_DEFINES_SVH
`define PIPE_TRACE_DEFINES_SVH

// CPU side values
`define PT_PC_W        32
`define PT_INSTR_W     32

// Sequence tag, wraps freely
`define PT_TAG_W       8

// Cycle stamp, latency is taken modulo this width
`define PT_CYCLE_W     16

// Per instruction stall count, saturates
`define PT_STALL_W     8

// Running total of squashed slots
`define PT_SQUASH_W    16

// IF, ID, EX, MEM, WB
`define PT_NUM_STAGES  5

`endif

// ==== src/pipe_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// CPU side value types
// Program counter and instruction word as seen at fetch
//////////////////////////////////////////////////////////////////////
`include "pipe_trace_defines.svh"

package pipe_pkg;

  // Fetch address of an instruction
  typedef logic [`PT_PC_W-1:0] pc_t;

  // Raw instruction word, carried untouched to retirement
  typedef logic [`PT_INSTR_W-1:0] instr_t;

endpackage

// ==== src/trace_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Trace bookkeeping types
// Tags, cycle stamps and the counters kept per slot and overall
//////////////////////////////////////////////////////////////////////
`include "pipe_trace_defines.svh"

package trace_pkg;

  // Sequence tag given to each fetch
  // Wraps after 2**PT_TAG_W fetches
  typedef logic [`PT_TAG_W-1:0] tag_t;

  // Free running cycle stamp
  // Differences are taken modulo the width
  typedef logic [`PT_CYCLE_W-1:0] cycle_t;

  // Stall cycles seen by one instruction in IF or ID
  // Saturates at all ones
  typedef logic [`PT_STALL_W-1:0] stall_cnt_t;

  // Total of IF and ID occupants removed by flushes
  typedef logic [`PT_SQUASH_W-1:0] squash_cnt_t;

endpackage

// ==== src/fetch_capture.sv ====
//////////////////////////////////////////////////////////////////////
// Fetch capture
// Stamps each fetch strobe with a sequence tag and its fetch cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module fetch_capture
  import pipe_pkg::*;
  import trace_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   fetch_valid,
  input  pc_t    fetch_pc,
  input  instr_t fetch_instr,
  output logic   new_valid,
  output tag_t   new_tag,
  output pc_t    new_pc,
  output instr_t new_instr,
  output cycle_t new_cycle,
  output cycle_t now_cycle
);

  cycle_t cycle_cnt;
  tag_t   tag_cnt;

  // Cycle counter, zero in the first cycle after reset release
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  // Next tag to hand out
  // Moves only when a fetch is taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_cnt <= '0;
    end else if (fetch_valid) begin
      tag_cnt <= tag_cnt + 1'b1;
    end
  end

  // Stamped fetch, same cycle as the strobe
  assign new_valid = fetch_valid;
  assign new_tag   = tag_cnt;
  assign new_pc    = fetch_pc;
  assign new_instr = fetch_instr;
  assign new_cycle = cycle_cnt;

  // Current cycle for latency at retirement
  assign now_cycle = cycle_cnt;

endmodule

// ==== src/stage_tracker.sv ====
//////////////////////////////////////////////////////////////////////
// Stage tracker
// Five occupancy slots following the CPU through IF to WB,
// with stall hold, EX bubble, flush squash and squash counting
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pipe_trace_defines.svh"

module stage_tracker
  import pipe_pkg::*;
  import trace_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        new_valid,
  input  tag_t        new_tag,
  input  pc_t         new_pc,
  input  instr_t      new_instr,
  input  cycle_t      new_cycle,
  input  logic        stall,
  input  logic        flush,
  output logic        wb_valid,
  output tag_t        wb_tag,
  output pc_t         wb_pc,
  output instr_t      wb_instr,
  output cycle_t      wb_fetch_cycle,
  output stall_cnt_t  wb_stalls,
  output squash_cnt_t squash_count
);

  localparam int NS    = `PT_NUM_STAGES;
  localparam int S_IF  = 0;
  localparam int S_ID  = 1;
  localparam int S_EX  = 2;
  localparam int S_MEM = 3;
  localparam int S_WB  = 4;

  // Slot contents, index is the stage
  logic        slot_valid  [NS];
  tag_t        slot_tag    [NS];
  pc_t         slot_pc     [NS];
  instr_t      slot_instr  [NS];
  cycle_t      slot_cycle  [NS];
  stall_cnt_t  slot_stalls [NS];

  squash_cnt_t squash_cnt;
  squash_cnt_t squash_inc;
  logic        hold_front;

  // Flush wins over stall for IF and ID
  assign hold_front = stall && !flush;
  // Occupied IF and ID slots lost on a flush
  assign squash_inc = squash_cnt_t'(slot_valid[S_IF]) + squash_cnt_t'(slot_valid[S_ID]);

  function automatic stall_cnt_t sat_inc(stall_cnt_t v);
    return (&v) ? v : stall_cnt_t'(v + 1'b1);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Occupancy and squash total
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NS; i++) begin
        slot_valid[i] <= 1'b0;
      end
      squash_cnt <= '0;
    end else begin
      if (flush) begin
        // New fetch still enters, ID occupant never reaches EX
        slot_valid[S_IF] <= new_valid;
        slot_valid[S_ID] <= 1'b0;
        slot_valid[S_EX] <= 1'b0;
        squash_cnt       <= squash_cnt + squash_inc;
      end else if (stall) begin
        // IF and ID hold, bubble into EX
        slot_valid[S_EX] <= 1'b0;
      end else begin
        slot_valid[S_IF] <= new_valid;
        slot_valid[S_ID] <= slot_valid[S_IF];
        slot_valid[S_EX] <= slot_valid[S_ID];
      end
      // Back end never stalls, WB empties every edge
      slot_valid[S_MEM] <= slot_valid[S_EX];
      slot_valid[S_WB]  <= slot_valid[S_MEM];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Slot payload
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (hold_front) begin
      // Count the stall against each held occupant
      for (int i = S_IF; i <= S_ID; i++) begin
        if (slot_valid[i]) begin
          slot_stalls[i] <= sat_inc(slot_stalls[i]);
        end
      end
    end else begin
      slot_tag[S_IF]    <= new_tag;
      slot_pc[S_IF]     <= new_pc;
      slot_instr[S_IF]  <= new_instr;
      slot_cycle[S_IF]  <= new_cycle;
      slot_stalls[S_IF] <= '0;
      slot_tag[S_ID]    <= slot_tag[S_IF];
      slot_pc[S_ID]     <= slot_pc[S_IF];
      slot_instr[S_ID]  <= slot_instr[S_IF];
      slot_cycle[S_ID]  <= slot_cycle[S_IF];
      slot_stalls[S_ID] <= slot_stalls[S_IF];
    end
    // EX onward copies blindly, valid bits decide what counts
    for (int i = S_EX; i < NS; i++) begin
      slot_tag[i]    <= slot_tag[i-1];
      slot_pc[i]     <= slot_pc[i-1];
      slot_instr[i]  <= slot_instr[i-1];
      slot_cycle[i]  <= slot_cycle[i-1];
      slot_stalls[i] <= slot_stalls[i-1];
    end
  end

  assign wb_valid       = slot_valid[S_WB];
  assign wb_tag         = slot_tag[S_WB];
  assign wb_pc          = slot_pc[S_WB];
  assign wb_instr       = slot_instr[S_WB];
  assign wb_fetch_cycle = slot_cycle[S_WB];
  assign wb_stalls      = slot_stalls[S_WB];
  assign squash_count   = squash_cnt;

  // CPU may only fetch during a stall if it flushes too
  a_no_fetch_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !(new_valid && stall && !flush));

  // One instruction occupies WB for exactly one cycle
  a_wb_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    slot_valid[S_WB] |=> !(slot_valid[S_WB] && slot_tag[S_WB] == $past(slot_tag[S_WB])));

endmodule

// ==== src/retire_report.sv ====
//////////////////////////////////////////////////////////////////////
// Retire report
// Registers the WB occupant as a retirement record with its latency
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pipe_trace_defines.svh"

module retire_report
  import pipe_pkg::*;
  import trace_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wb_valid,
  input  tag_t       wb_tag,
  input  pc_t        wb_pc,
  input  instr_t     wb_instr,
  input  cycle_t     wb_fetch_cycle,
  input  stall_cnt_t wb_stalls,
  input  cycle_t     now_cycle,
  output logic       retire_valid,
  output tag_t       retire_tag,
  output pc_t        retire_pc,
  output instr_t     retire_instr,
  output cycle_t     retire_fetch_cycle,
  output stall_cnt_t retire_stalls,
  output cycle_t     retire_latency
);

  // Fetch strobe to retire strobe with no stall
  localparam cycle_t MIN_LATENCY = cycle_t'(`PT_NUM_STAGES + 1);

  cycle_t wb_latency;

  // Record shows up one cycle after WB, hence the +1
  assign wb_latency = cycle_t'(now_cycle - wb_fetch_cycle + 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= wb_valid;
    end
  end

  // Record fields, only loaded for a real occupant
  always_ff @(posedge clk) begin
    if (wb_valid) begin
      retire_tag         <= wb_tag;
      retire_pc          <= wb_pc;
      retire_instr       <= wb_instr;
      retire_fetch_cycle <= wb_fetch_cycle;
      retire_stalls      <= wb_stalls;
      retire_latency     <= wb_latency;
    end
  end

  // Latency from fetch stamp to retirement covers the whole pipe
  a_min_latency: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> retire_latency >= MIN_LATENCY);

endmodule

// ==== src/pipe_trace_top.sv ====
//////////////////////////////////////////////////////////////////////
// Pipeline trace unit top level
// Fetch capture, stage tracker and retire report in a chain
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module pipe_trace_top
  import pipe_pkg::*;
  import trace_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_valid,
  input  pc_t         fetch_pc,
  input  instr_t      fetch_instr,
  input  logic        stall,
  input  logic        flush,
  output logic        retire_valid,
  output tag_t        retire_tag,
  output pc_t         retire_pc,
  output instr_t      retire_instr,
  output cycle_t      retire_fetch_cycle,
  output stall_cnt_t  retire_stalls,
  output cycle_t      retire_latency,
  output squash_cnt_t squash_count
);

  // Stamped fetch into the tracker
  logic   new_valid;
  tag_t   new_tag;
  pc_t    new_pc;
  instr_t new_instr;
  cycle_t new_cycle;
  cycle_t now_cycle;

  // WB occupant into the report
  logic       wb_valid;
  tag_t       wb_tag;
  pc_t        wb_pc;
  instr_t     wb_instr;
  cycle_t     wb_fetch_cycle;
  stall_cnt_t wb_stalls;

  fetch_capture u_fetch_capture (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr),
    .new_valid   (new_valid),
    .new_tag     (new_tag),
    .new_pc      (new_pc),
    .new_instr   (new_instr),
    .new_cycle   (new_cycle),
    .now_cycle   (now_cycle)
  );

  stage_tracker u_stage_tracker (
    .clk            (clk),
    .rst_n          (rst_n),
    .new_valid      (new_valid),
    .new_tag        (new_tag),
    .new_pc         (new_pc),
    .new_instr      (new_instr),
    .new_cycle      (new_cycle),
    .stall          (stall),
    .flush          (flush),
    .wb_valid       (wb_valid),
    .wb_tag         (wb_tag),
    .wb_pc          (wb_pc),
    .wb_instr       (wb_instr),
    .wb_fetch_cycle (wb_fetch_cycle),
    .wb_stalls      (wb_stalls),
    .squash_count   (squash_count)
  );

  retire_report u_retire_report (
    .clk                (clk),
    .rst_n              (rst_n),
    .wb_valid           (wb_valid),
    .wb_tag             (wb_tag),
    .wb_pc              (wb_pc),
    .wb_instr           (wb_instr),
    .wb_fetch_cycle     (wb_fetch_cycle),
    .wb_stalls          (wb_stalls),
    .now_cycle          (now_cycle),
    .retire_valid       (retire_valid),
    .retire_tag         (retire_tag),
    .retire_pc          (retire_pc),
    .retire_instr       (retire_instr),
    .retire_fetch_cycle (retire_fetch_cycle),
    .retire_stalls      (retire_stalls),
    .retire_latency     (retire_latency)
  );

endmodule

// ==== bench/trace_checker.sv ====
//////////////////////////////////////////////////////////////////////
// Trace checker
// Compares each retirement record and the final squash total
// with the expected lines of the vector file, reports per test
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module trace_checker
  import pipe_pkg::*;
  import trace_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        retire_valid,
  input  tag_t        retire_tag,
  input  pc_t         retire_pc,
  input  instr_t      retire_instr,
  input  cycle_t      retire_fetch_cycle,
  input  stall_cnt_t  retire_stalls,
  input  cycle_t      retire_latency,
  input  squash_cnt_t squash_count,
  input  logic        end_of_run,
  output logic        all_seen,
  output logic        report_done,
  output int          fail_count
);

  // Nothing can retire in the first cycles after reset release
  localparam int RESET_WINDOW = 6;
  localparam int RESET_TEST   = 5;

  // Expected records, in retirement order
  int         exp_test   [$];
  tag_t       exp_tag    [$];
  cycle_t     exp_fcyc   [$];
  pc_t        exp_pc     [$];
  instr_t     exp_instr  [$];
  stall_cnt_t exp_stalls [$];
  cycle_t     exp_lat    [$];
  int         exp_squash = -1;

  int   test_errs   [1:RESET_TEST] = '{default: 0};
  int   test_checks [1:RESET_TEST] = '{default: 0};
  int   rec_idx    = 0;
  int   cyc        = 0;
  int   checks     = 0;
  int   errors     = 0;
  int   extra_recs = 0;
  logic seen_r     = 1'b0;
  logic done_r     = 1'b0;

  assign all_seen    = seen_r;
  assign report_done = done_r;
  assign fail_count  = errors;

  // E and Q lines only
  initial begin : load_expected
    int               fd;
    int               n;
    int               t;
    int               tg;
    int               fc;
    int               st;
    int               lat;
    logic [31:0]      pc;
    logic [31:0]      ins;
    logic [7:0]       kind;
    logic [8*256-1:0] rest;
    fd = $fopen("bench/trace_vectors.txt", "r");
    if (fd == 0) begin
      $display("Checker cannot open bench/trace_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        kind = 8'h00;
        n = $fscanf(fd, "%s", kind);
        if (kind == "E") begin
          n = $fscanf(fd, "%d %d %d %h %h %d %d", t, tg, fc, pc, ins, st, lat);
          if (n == 7) begin
            exp_test.push_back(t);
            exp_tag.push_back(tag_t'(tg));
            exp_fcyc.push_back(cycle_t'(fc));
            exp_pc.push_back(pc_t'(pc));
            exp_instr.push_back(instr_t'(ins));
            exp_stalls.push_back(stall_cnt_t'(st));
            exp_lat.push_back(cycle_t'(lat));
          end
        end else if (kind == "Q") begin
          n = $fscanf(fd, "%d", exp_squash);
        end else begin
          n = $fgets(rest, fd);
        end
      end
      $fclose(fd);
    end
  end

  function automatic string test_name(input int id);
    case (id)
      1:       return "back-to-back flow";
      2:       return "stall in decode";
      3:       return "flush";
      4:       return "flush during stall";
      5:       return "reset state";
      default: return "unknown";
    endcase
  endfunction

  task automatic print_test_line(input int id);
    $display("Test %0d %s: %0d checks, %0d errors, %s", id, test_name(id),
             test_checks[id], test_errs[id], (test_errs[id] == 0) ? "pass" : "FAIL");
  endtask

  task automatic compare_field(input int id, input string what,
                               input logic [31:0] got, input logic [31:0] want);
    checks++;
    test_checks[id]++;
    if (got !== want) begin
      $display("[ERROR] %0t ns test %0d record %0d %s is 0x%0h, expected 0x%0h",
               $time, id, rec_idx, what, got, want);
      test_errs[id]++;
      errors++;
    end
  endtask

  // Idle outputs while in reset and just after release
  task automatic check_reset_state();
    checks++;
    test_checks[RESET_TEST]++;
    if (retire_valid !== 1'b0 || squash_count !== '0) begin
      $display("[ERROR] %0t ns reset state shows retire_valid %b and squash_count %0d",
               $time, retire_valid, squash_count);
      test_errs[RESET_TEST]++;
      errors++;
    end
  endtask

  task automatic check_record();
    int id;
    if (rec_idx >= exp_pc.size()) begin
      $display("Unexpected extra record at %0t ns with tag %0d and pc 0x%h",
               $time, retire_tag, retire_pc);
      extra_recs++;
      errors++;
    end else begin
      id = exp_test[rec_idx];
      compare_field(id, "tag", 32'(retire_tag), 32'(exp_tag[rec_idx]));
      compare_field(id, "fetch cycle", 32'(retire_fetch_cycle), 32'(exp_fcyc[rec_idx]));
      compare_field(id, "pc", 32'(retire_pc), 32'(exp_pc[rec_idx]));
      compare_field(id, "instr", 32'(retire_instr), 32'(exp_instr[rec_idx]));
      compare_field(id, "stalls", 32'(retire_stalls), 32'(exp_stalls[rec_idx]));
      compare_field(id, "latency", 32'(retire_latency), 32'(exp_lat[rec_idx]));
      rec_idx++;
      // Last record of a test closes it
      if (rec_idx == exp_pc.size() || exp_test[rec_idx] != id) begin
        print_test_line(id);
      end
      if (rec_idx == exp_pc.size()) begin
        seen_r = 1'b1;
      end
    end
  endtask

  task automatic finish_report();
    if (exp_pc.size() == 0) begin
      $display("No expected records were loaded from the vector file");
      errors++;
    end else if (rec_idx < exp_pc.size()) begin
      $display("Missing records, only %0d of %0d expected records arrived",
               rec_idx, exp_pc.size());
      errors++;
      // Close the tests whose records never all came
      for (int i = rec_idx; i < exp_pc.size(); i++) begin
        if (i == exp_pc.size() - 1 || exp_test[i+1] != exp_test[i]) begin
          test_errs[exp_test[i]]++;
          print_test_line(exp_test[i]);
        end
      end
    end
    if (exp_squash < 0) begin
      $display("No expected squash count was loaded from the vector file");
      errors++;
    end else begin
      checks++;
      if (32'(squash_count) !== 32'(exp_squash)) begin
        $display("[ERROR] %0t ns squash_count is %0d, expected %0d",
                 $time, squash_count, exp_squash);
        errors++;
      end
      $display("Squash total: %0d, expected %0d", squash_count, exp_squash);
    end
    $display("Summary: %0d checks, %0d errors, %0d of %0d records, %0d extra",
             checks, errors, rec_idx, exp_pc.size(), extra_recs);
    done_r = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sampling on the falling edge, away from DUT updates
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (!rst_n) begin
      check_reset_state();
    end else begin
      if (cyc < RESET_WINDOW) begin
        check_reset_state();
      end
      if (cyc == RESET_WINDOW - 1) begin
        print_test_line(RESET_TEST);
      end
      cyc++;
      if (retire_valid) begin
        check_record();
      end
      if (end_of_run && !done_r) begin
        finish_report();
      end
    end
  end

endmodule

// ==== bench/tb_pipe_trace.sv ====
//////////////////////////////////////////////////////////////////////
// Pipeline trace unit testbench
// Drives fetch, stall and flush once per cycle from the vector file
// and hands the retirement records to the trace checker
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_pipe_trace
  import pipe_pkg::*;
  import trace_pkg::*;
();

  localparam int HALF_PERIOD  = 20;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 4;
  // Five stages plus the output register, room for a stray record
  localparam int DRAIN_CYCLES = 7;
  localparam int SLACK_CYCLES = 20;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        fetch_valid;
  pc_t         fetch_pc;
  instr_t      fetch_instr;
  logic        stall;
  logic        flush;
  logic        retire_valid;
  tag_t        retire_tag;
  pc_t         retire_pc;
  instr_t      retire_instr;
  cycle_t      retire_fetch_cycle;
  stall_cnt_t  retire_stalls;
  cycle_t      retire_latency;
  squash_cnt_t squash_count;

  // Run control between stimulus and checker
  logic end_of_run;
  logic all_seen;
  logic report_done;
  int   fail_count;

  // One entry per S line, index is the cycle count after reset release
  logic   s_valid [$];
  pc_t    s_pc    [$];
  instr_t s_instr [$];
  logic   s_stall [$];
  logic   s_flush [$];
  int     cycle_limit;
  int     run_cycles;

  pipe_trace_top dut (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_valid        (fetch_valid),
    .fetch_pc           (fetch_pc),
    .fetch_instr        (fetch_instr),
    .stall              (stall),
    .flush              (flush),
    .retire_valid       (retire_valid),
    .retire_tag         (retire_tag),
    .retire_pc          (retire_pc),
    .retire_instr       (retire_instr),
    .retire_fetch_cycle (retire_fetch_cycle),
    .retire_stalls      (retire_stalls),
    .retire_latency     (retire_latency),
    .squash_count       (squash_count)
  );

  trace_checker u_trace_checker (
    .clk                (clk),
    .rst_n              (rst_n),
    .retire_valid       (retire_valid),
    .retire_tag         (retire_tag),
    .retire_pc          (retire_pc),
    .retire_instr       (retire_instr),
    .retire_fetch_cycle (retire_fetch_cycle),
    .retire_stalls      (retire_stalls),
    .retire_latency     (retire_latency),
    .squash_count       (squash_count),
    .end_of_run         (end_of_run),
    .all_seen           (all_seen),
    .report_done        (report_done),
    .fail_count         (fail_count)
  );

  initial begin : clock_gen
    forever #HALF_PERIOD clk = ~clk;
  end

  // Pull the S lines, every other line kind is skipped
  task automatic load_stimulus(output bit ok);
    int               fd;
    int               n;
    int               v;
    int               st;
    int               fl;
    logic [31:0]      pc;
    logic [31:0]      ins;
    logic [7:0]       kind;
    logic [8*256-1:0] rest;
    ok = 1'b0;
    fd = $fopen("bench/trace_vectors.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        kind = 8'h00;
        n = $fscanf(fd, "%s", kind);
        if (kind == "S") begin
          n = $fscanf(fd, "%d %h %h %d %d", v, pc, ins, st, fl);
          if (n == 5) begin
            s_valid.push_back(v != 0);
            s_pc.push_back(pc_t'(pc));
            s_instr.push_back(instr_t'(ins));
            s_stall.push_back(st != 0);
            s_flush.push_back(fl != 0);
          end
        end else begin
          n = $fgets(rest, fd);
        end
      end
      $fclose(fd);
      ok = (s_valid.size() > 0);
    end
  endtask

  task automatic drive_cycle(input int i);
    fetch_valid = s_valid[i];
    fetch_pc    = s_pc[i];
    fetch_instr = s_instr[i];
    stall       = s_stall[i];
    flush       = s_flush[i];
  endtask

  // Quiet CPU once the file runs out
  task automatic drive_idle();
    fetch_valid = 1'b0;
    fetch_pc    = '0;
    fetch_instr = '0;
    stall       = 1'b0;
    flush       = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and end of run
  //////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    bit loaded;
    int waited;
    drive_idle();
    rst_n       = 1'b0;
    end_of_run  = 1'b0;
    cycle_limit = 0;
    load_stimulus(loaded);
    if (!loaded) begin
      $display("Could not read any stimulus lines from bench/trace_vectors.txt");
      $display("Simulation failed");
      $finish;
    end else begin
      cycle_limit = s_valid.size() + SLACK_CYCLES;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst_n = 1'b1;
      // Line i is presented while the DUT cycle counter reads i
      for (int i = 0; i < s_valid.size(); i++) begin
        drive_cycle(i);
        @(posedge clk);
        #DRIVE_DELAY;
      end
      drive_idle();
      // Pipe empties within its depth once fetch stops
      waited = 0;
      while (!all_seen && waited < DRAIN_CYCLES) begin
        @(posedge clk);
        waited++;
      end
      repeat (DRAIN_CYCLES) @(posedge clk);
      end_of_run = 1'b1;
      while (!report_done) @(posedge clk);
      if (fail_count == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

  // Watchdog counts cycles from reset release
  initial begin : watchdog
    run_cycles = 0;
    @(posedge rst_n);
    while (run_cycles < cycle_limit) begin
      @(posedge clk);
      run_cycles++;
    end
    $display("Timeout after %0d cycles, the run never reached its closing report", run_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== bench/trace_vectors.txt ====
# S fetch_valid fetch_pc fetch_instr stall flush   (one line per cycle from reset release)
# E test tag fetch_cycle pc instr stalls latency  (expected records in order) and Q squash_count
# Test 1 back-to-back fetches in cycles 0 to 5
S 1 00000100 00100093 0 0
S 1 00000104 00200113 0 0
S 1 00000108 00300193 0 0
S 1 0000010c 00400213 0 0
S 1 00000110 00500293 0 0
S 1 00000114 00600313 0 0
# Test 2 older fetch, then two fetches held by a two cycle stall
S 1 00000200 002081b3 0 0
S 1 00000204 40110233 0 0
S 1 00000208 0041a023 0 0
S 0 00000000 00000000 1 0
S 0 00000000 00000000 1 0
S 0 00000000 00000000 0 0
# Test 3 two fetches squashed, fetch in the flush cycle survives
S 1 00000300 00c000ef 0 0
S 1 00000304 00000013 0 0
S 1 00000308 fe0008e3 0 1
S 1 0000030c 00a00513 0 0
# Test 4 flush in the second stall cycle
S 1 00000400 0000a583 0 0
S 1 00000404 00b50633 0 0
S 0 00000000 00000000 1 0
S 0 00000000 00000000 1 1
S 1 00000408 00c586b3 0 0
E 1 0 0 00000100 00100093 0 6
E 1 1 1 00000104 00200113 0 6
E 1 2 2 00000108 00300193 0 6
E 1 3 3 0000010c 00400213 0 6
E 1 4 4 00000110 00500293 0 6
E 1 5 5 00000114 00600313 0 6
E 2 6 6 00000200 002081b3 0 6
E 2 7 7 00000204 40110233 2 8
E 2 8 8 00000208 0041a023 2 8
E 3 11 14 00000308 fe0008e3 0 6
E 3 12 15 0000030c 00a00513 0 6
E 4 15 20 00000408 00c586b3 0 6
Q 4

// ==== compile.f ====
+incdir+include
src/pipe_pkg.sv
src/trace_pkg.sv
src/fetch_capture.sv
src/stage_tracker.sv
src/retire_report.sv
src/pipe_trace_top.sv
bench/trace_checker.sv
bench/tb_pipe_trace.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pipeline trace testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
  -f compile.f --top-module tb_pipe_trace -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build returned status $status"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi

exit 0
